//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

    // ------------------------------------------------
    // Bus and pad widths
    // ------------------------------------------------
    localparam int WB_WIDTH = 32;                // Wishbone address/data
    localparam int WB_SEL_W = 4;                 // Byte enables
    localparam int IO_W     = 38;                // Pads
    localparam int IRQ_W    = 3;                 // User interrupt lines
    localparam int GPO_W    = 16;                // General purpose outputs

    // ------------------------------------------------
    // Address map
    // ------------------------------------------------
    localparam int SLV_FIELD_HI = 31;
    localparam int SLV_FIELD_LO = 28;
    localparam logic [3:0] SLV_GLBL = 4'h1;      // Global config block
    localparam logic [3:0] SLV_UART = 4'h2;      // UART transmitter

    localparam int REG_IDX_HI = 3;               // Word index inside a slave
    localparam int REG_IDX_LO = 2;

    localparam logic [1:0] GLBL_ID      = 2'd0;
    localparam logic [1:0] GLBL_SCRATCH = 2'd1;
    localparam logic [1:0] GLBL_IRQ     = 2'd2;
    localparam logic [1:0] GLBL_GPO     = 2'd3;

    localparam logic [1:0] UART_CTRL    = 2'd0;
    localparam logic [1:0] UART_DIV     = 2'd1;
    localparam logic [1:0] UART_TXDATA  = 2'd2;
    localparam logic [1:0] UART_STATUS  = 2'd3;

    // Reset values, pad positions
    localparam logic [WB_WIDTH-1:0] CHIP_ID   = 32'h5946_0003;
    localparam logic [15:0]         UART_DIV_RST = 16'd433;  // Bit time is div + 1
    localparam int                  UART_TX_PAD  = 37;
    localparam int                  UART_RX_PAD  = 36;
    localparam logic [WB_WIDTH-1:0] ERR_RDATA = '0;

    // Staged request
    typedef struct packed {
        logic [WB_WIDTH-1:0] adr;
        logic                we;
        logic [WB_WIDTH-1:0] dat;
        logic [WB_SEL_W-1:0] sel;
    } wb_req_t;

    // Staged response
    typedef struct packed {
        logic [WB_WIDTH-1:0] dat;
        logic                err;                // Unmapped address
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- design/wb_stage.sv
`default_nettype none

module wb_stage #(
    parameter type T_PAYLOAD = logic [31:0]
) (
    input  wire logic     wb_clk_i,
    input  wire logic     rst_i,
    input  wire logic     load_i,             // Capture data_i
    input  wire logic     clear_i,            // Consumer done with entry
    input  wire T_PAYLOAD data_i,
    output logic          valid_o,
    output T_PAYLOAD      data_o
);

    logic     valid_q;
    T_PAYLOAD data_q;

    // Load wins over clear on the valid flag
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end
    end

    // Payload only
    always_ff @(posedge wb_clk_i) begin
        if (load_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------
    // Never overwrite an entry still waiting for its consumer
    a_no_overrun: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        load_i |-> (!valid_q || clear_i));

endmodule

`default_nettype wire

//--- design/wb_interconnect.sv
`default_nettype none

module wb_interconnect (
    input  wire logic                          wb_clk_i,
    input  wire logic                          rst_i,

    // External master, Wishbone classic
    input  wire logic                          wbd_ext_cyc_i,
    input  wire logic                          wbd_ext_stb_i,
    input  wire logic [core_pkg::WB_WIDTH-1:0] wbd_ext_adr_i,
    input  wire logic                          wbd_ext_we_i,
    input  wire logic [core_pkg::WB_WIDTH-1:0] wbd_ext_dat_i,
    input  wire logic [core_pkg::WB_SEL_W-1:0] wbd_ext_sel_i,
    output logic      [core_pkg::WB_WIDTH-1:0] wbd_ext_dat_o,
    output logic                               wbd_ext_ack_o,
    output logic                               wbd_ext_err_o,

    // Register bus to the slaves
    output logic                               glbl_cs_o,
    output logic                               uart_cs_o,
    output logic                               reg_wr_o,
    output logic      [1:0]                    reg_addr_o,
    output logic      [core_pkg::WB_WIDTH-1:0] reg_wdata_o,
    output logic      [core_pkg::WB_SEL_W-1:0] reg_be_o,
    input  wire logic [core_pkg::WB_WIDTH-1:0] glbl_rdata_i,
    input  wire logic                          glbl_ack_i,
    input  wire logic [core_pkg::WB_WIDTH-1:0] uart_rdata_i,
    input  wire logic                          uart_ack_i
);

    import core_pkg::*;

    logic    busy_q;                          // Transaction open
    logic    req_load, req_vld;
    wb_req_t req_in, req_q;
    logic    rsp_load, rsp_vld;
    wb_rsp_t rsp_in, rsp_q;
    logic    hit_glbl, hit_uart, unmapped, slave_ack;

    // ------------------------------------------------
    // Request stage
    // ------------------------------------------------
    assign req_load = wbd_ext_cyc_i && wbd_ext_stb_i && !busy_q;
    assign req_in   = '{adr: wbd_ext_adr_i, we: wbd_ext_we_i,
                        dat: wbd_ext_dat_i, sel: wbd_ext_sel_i};

    wb_stage #(.T_PAYLOAD(wb_req_t)) u_req_stage (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .load_i   (req_load),
        .clear_i  (rsp_load),                 // Freed once the answer is staged
        .data_i   (req_in),
        .valid_o  (req_vld),
        .data_o   (req_q)
    );

    // Slave decode on the staged address
    assign hit_glbl = req_vld && (req_q.adr[SLV_FIELD_HI:SLV_FIELD_LO] == SLV_GLBL);
    assign hit_uart = req_vld && (req_q.adr[SLV_FIELD_HI:SLV_FIELD_LO] == SLV_UART);
    assign unmapped = req_vld && !hit_glbl && !hit_uart;

    assign glbl_cs_o   = hit_glbl;
    assign uart_cs_o   = hit_uart;
    assign reg_wr_o    = req_q.we;
    assign reg_addr_o  = req_q.adr[REG_IDX_HI:REG_IDX_LO];
    assign reg_wdata_o = req_q.dat;
    assign reg_be_o    = req_q.sel;

    // ------------------------------------------------
    // Response stage
    // ------------------------------------------------
    assign slave_ack = glbl_ack_i || uart_ack_i;
    assign rsp_load  = slave_ack || unmapped;
    assign rsp_in.dat = glbl_ack_i ? glbl_rdata_i :
                        uart_ack_i ? uart_rdata_i : ERR_RDATA;
    assign rsp_in.err = !slave_ack;           // Only unmapped gets here

    wb_stage #(.T_PAYLOAD(wb_rsp_t)) u_rsp_stage (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .load_i   (rsp_load),
        .clear_i  (rsp_vld),                  // Presented for one cycle only
        .data_i   (rsp_in),
        .valid_o  (rsp_vld),
        .data_o   (rsp_q)
    );

    assign wbd_ext_ack_o = rsp_vld && !rsp_q.err;
    assign wbd_ext_err_o = rsp_vld && rsp_q.err;
    assign wbd_ext_dat_o = rsp_q.dat;

    // Open from staging until the answer goes out
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else if (req_load) begin
            busy_q <= 1'b1;
        end else if (rsp_vld) begin
            busy_q <= 1'b0;
        end
    end

    // Checks
    a_one_select: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        !(glbl_cs_o && uart_cs_o));
    a_glbl_ack_cs: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        glbl_ack_i |-> glbl_cs_o);
    a_uart_ack_cs: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        uart_ack_i |-> uart_cs_o);

endmodule

`default_nettype wire

//--- design/glbl_cfg.sv
`default_nettype none

module glbl_cfg (
    input  wire logic                          wb_clk_i,
    input  wire logic                          rst_i,

    // Register bus
    input  wire logic                          reg_cs_i,
    input  wire logic                          reg_wr_i,
    input  wire logic [1:0]                    reg_addr_i,
    input  wire logic [core_pkg::WB_WIDTH-1:0] reg_wdata_i,
    input  wire logic [core_pkg::WB_SEL_W-1:0] reg_be_i,
    output logic      [core_pkg::WB_WIDTH-1:0] reg_rdata_o,
    output logic                               reg_ack_o,

    output logic      [core_pkg::IRQ_W-1:0]    user_irq_o,
    output logic      [core_pkg::GPO_W-1:0]    gpo_o
);

    import core_pkg::*;

    logic                access;              // First cycle of a select
    logic                wr_stb;
    logic                ack_q;
    logic [WB_WIDTH-1:0] scratch_q;
    logic [IRQ_W-1:0]    irq_q;
    logic [GPO_W-1:0]    gpo_q;
    logic [WB_WIDTH-1:0] rdata_mux;
    logic [WB_WIDTH-1:0] rdata_q;

    assign access = reg_cs_i && !ack_q;       // cs still high in the ack cycle
    assign wr_stb = access && reg_wr_i;

    // ------------------------------------------------
    // Writable registers
    // ------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q     <= 1'b0;
            scratch_q <= '0;
            irq_q     <= '0;
            gpo_q     <= '0;
        end else begin
            ack_q <= access;                  // One-cycle ack
            if (wr_stb) begin
                case (reg_addr_i)
                    GLBL_SCRATCH: begin
                        for (int b = 0; b < WB_SEL_W; b++) begin
                            if (reg_be_i[b]) begin
                                scratch_q[b*8 +: 8] <= reg_wdata_i[b*8 +: 8];
                            end
                        end
                    end
                    GLBL_IRQ: if (reg_be_i[0]) irq_q <= reg_wdata_i[IRQ_W-1:0];
                    GLBL_GPO: begin
                        if (reg_be_i[0]) gpo_q[7:0]  <= reg_wdata_i[7:0];
                        if (reg_be_i[1]) gpo_q[15:8] <= reg_wdata_i[15:8];
                    end
                    default: ;                // ID is read-only
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        case (reg_addr_i)
            GLBL_ID:      rdata_mux = CHIP_ID;
            GLBL_SCRATCH: rdata_mux = scratch_q;
            GLBL_IRQ:     rdata_mux = {{(WB_WIDTH-IRQ_W){1'b0}}, irq_q};
            default:      rdata_mux = {{(WB_WIDTH-GPO_W){1'b0}}, gpo_q};
        endcase
    end

    // Read data lines up with ack
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= rdata_mux;
        end
    end

    assign reg_rdata_o = rdata_q;
    assign reg_ack_o   = ack_q;
    assign user_irq_o  = irq_q;
    assign gpo_o       = gpo_q;

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------
    a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        reg_ack_o |=> !reg_ack_o);

endmodule

`default_nettype wire

//--- design/uart_core.sv
`default_nettype none

module uart_core (
    input  wire logic                          wb_clk_i,
    input  wire logic                          rst_i,

    // Register bus
    input  wire logic                          reg_cs_i,
    input  wire logic                          reg_wr_i,
    input  wire logic [1:0]                    reg_addr_i,
    input  wire logic [core_pkg::WB_WIDTH-1:0] reg_wdata_i,
    input  wire logic [core_pkg::WB_SEL_W-1:0] reg_be_i,
    output logic      [core_pkg::WB_WIDTH-1:0] reg_rdata_o,
    output logic                               reg_ack_o,

    output logic                               uart_tx_o       // Serial line
);

    import core_pkg::*;

    logic                access, tx_write, hold, take, load_frame;
    logic                ack_q;
    logic                tx_en_q;             // CTRL bit 0
    logic [15:0]         div_q;
    logic [7:0]          txdata_q;
    logic [15:0]         baud_cnt;
    logic [3:0]          bits_left;           // Bits of the frame still to send
    logic [9:0]          shift_q;             // Stop, data, start
    logic                busy;
    logic [WB_WIDTH-1:0] rdata_q;

    assign busy       = (bits_left != 4'd0);
    assign access     = reg_cs_i && !ack_q;
    assign tx_write   = access && reg_wr_i && (reg_addr_i == UART_TXDATA);
    assign hold       = tx_write && busy;     // Back-pressure until shifter idle
    assign take       = access && !hold;
    assign load_frame = take && tx_write && tx_en_q && reg_be_i[0];

    // ------------------------------------------------
    // Register block
    // ------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q    <= 1'b0;
            tx_en_q  <= 1'b0;
            div_q    <= UART_DIV_RST;
            txdata_q <= '0;
        end else begin
            ack_q <= take;
            if (take && reg_wr_i) begin
                if (reg_addr_i == UART_CTRL && reg_be_i[0]) tx_en_q <= reg_wdata_i[0];
                if (reg_addr_i == UART_DIV) begin
                    if (reg_be_i[0]) div_q[7:0]  <= reg_wdata_i[7:0];
                    if (reg_be_i[1]) div_q[15:8] <= reg_wdata_i[15:8];
                end
            end
            if (load_frame) txdata_q <= reg_wdata_i[7:0];  // Disabled writes dropped
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (take) begin
            case (reg_addr_i)
                UART_CTRL:   rdata_q <= {31'b0, tx_en_q};
                UART_DIV:    rdata_q <= {16'b0, div_q};
                UART_TXDATA: rdata_q <= {24'b0, txdata_q};
                default:     rdata_q <= {31'b0, busy};      // STATUS
            endcase
        end
    end

    // ------------------------------------------------
    // Bit-rate counter and frame shifter
    // ------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            baud_cnt  <= '0;
            bits_left <= '0;
            shift_q   <= '1;                  // Line idle high
        end else if (load_frame) begin
            shift_q   <= {1'b1, reg_wdata_i[7:0], 1'b0};
            bits_left <= 4'd10;
            baud_cnt  <= div_q;
        end else if (busy) begin
            if (baud_cnt == 16'd0) begin      // End of bit time
                shift_q   <= {1'b1, shift_q[9:1]};
                bits_left <= bits_left - 4'd1;
                baud_cnt  <= div_q;
            end else begin
                baud_cnt <= baud_cnt - 16'd1;
            end
        end
    end

    assign uart_tx_o   = shift_q[0];          // LSB first
    assign reg_rdata_o = rdata_q;
    assign reg_ack_o   = ack_q;

    // Checks
    a_no_load_busy: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        load_frame |-> !busy);

endmodule

`default_nettype wire

//--- design/digital_core.sv
`default_nettype none

module digital_core (
    input  wire logic                          wb_clk_i,
    input  wire logic                          rst_i,

    input  wire logic                          wbd_ext_cyc_i,
    input  wire logic                          wbd_ext_stb_i,
    input  wire logic [core_pkg::WB_WIDTH-1:0] wbd_ext_adr_i,
    input  wire logic                          wbd_ext_we_i,
    input  wire logic [core_pkg::WB_WIDTH-1:0] wbd_ext_dat_i,
    input  wire logic [core_pkg::WB_SEL_W-1:0] wbd_ext_sel_i,
    output logic      [core_pkg::WB_WIDTH-1:0] wbd_ext_dat_o,
    output logic                               wbd_ext_ack_o,
    output logic                               wbd_ext_err_o,

    output logic      [core_pkg::IO_W-1:0]     io_out_o,
    output logic      [core_pkg::IO_W-1:0]     io_oeb_o,        // Active low enable
    output logic      [core_pkg::IRQ_W-1:0]    user_irq_o
);

    import core_pkg::*;

    logic                glbl_cs, uart_cs, reg_wr;
    logic [1:0]          reg_addr;
    logic [WB_WIDTH-1:0] reg_wdata;
    logic [WB_SEL_W-1:0] reg_be;
    logic [WB_WIDTH-1:0] glbl_rdata, uart_rdata;
    logic                glbl_ack, uart_ack;
    logic [GPO_W-1:0]    gpo;
    logic                uart_tx;

    // ------------------------------------------------
    // Pad mapping
    // ------------------------------------------------
    always_comb begin
        io_out_o = '0;                        // Unused pads tied low
        io_oeb_o = '1;                        // and not driven
        io_out_o[GPO_W-1:0]    = gpo;
        io_oeb_o[GPO_W-1:0]    = '0;
        io_out_o[UART_TX_PAD]  = uart_tx;
        io_oeb_o[UART_TX_PAD]  = 1'b0;
        io_oeb_o[UART_RX_PAD]  = 1'b1;        // Rx pad stays an input
    end

    wb_interconnect u_intercon (
        .wb_clk_i      (wb_clk_i),      .rst_i         (rst_i),
        .wbd_ext_cyc_i (wbd_ext_cyc_i), .wbd_ext_stb_i (wbd_ext_stb_i),
        .wbd_ext_adr_i (wbd_ext_adr_i), .wbd_ext_we_i  (wbd_ext_we_i),
        .wbd_ext_dat_i (wbd_ext_dat_i), .wbd_ext_sel_i (wbd_ext_sel_i),
        .wbd_ext_dat_o (wbd_ext_dat_o), .wbd_ext_ack_o (wbd_ext_ack_o),
        .wbd_ext_err_o (wbd_ext_err_o),
        .glbl_cs_o     (glbl_cs),       .uart_cs_o     (uart_cs),
        .reg_wr_o      (reg_wr),        .reg_addr_o    (reg_addr),
        .reg_wdata_o   (reg_wdata),     .reg_be_o      (reg_be),
        .glbl_rdata_i  (glbl_rdata),    .glbl_ack_i    (glbl_ack),
        .uart_rdata_i  (uart_rdata),    .uart_ack_i    (uart_ack)
    );

    glbl_cfg u_glbl_cfg (
        .wb_clk_i    (wb_clk_i),   .rst_i       (rst_i),
        .reg_cs_i    (glbl_cs),    .reg_wr_i    (reg_wr),
        .reg_addr_i  (reg_addr),   .reg_wdata_i (reg_wdata),
        .reg_be_i    (reg_be),     .reg_rdata_o (glbl_rdata),
        .reg_ack_o   (glbl_ack),   .user_irq_o  (user_irq_o),
        .gpo_o       (gpo)
    );

    uart_core u_uart_core (
        .wb_clk_i    (wb_clk_i),   .rst_i       (rst_i),
        .reg_cs_i    (uart_cs),    .reg_wr_i    (reg_wr),
        .reg_addr_i  (reg_addr),   .reg_wdata_i (reg_wdata),
        .reg_be_i    (reg_be),     .reg_rdata_o (uart_rdata),
        .reg_ack_o   (uart_ack),   .uart_tx_o   (uart_tx)
    );

    // Slave ack reaches the master one cycle later
    a_ack_path: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        (glbl_ack || uart_ack) |=> wbd_ext_ack_o);

endmodule

`default_nettype wire

//--- verif/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// --------------------------------------------------
// Compare tasks, one per result kind
// --------------------------------------------------
task automatic compare_data(input string name, input logic [WB_WIDTH-1:0] got,
                            input logic [WB_WIDTH-1:0] exp);
    if (got !== exp) begin
        n_mis++;
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
endtask

task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        n_mis++;
        $display("mismatch io_out_o[%0d] byte: got 0x%h expected 0x%h", UART_TX_PAD, got, exp);
    end
endtask

task automatic compare_irq(input logic [IRQ_W-1:0] got, input logic [IRQ_W-1:0] exp);
    if (got !== exp) begin
        n_mis++;
        $display("mismatch user_irq_o: got 0x%h expected 0x%h", got, exp);
    end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        n_mis++;
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
endtask

task automatic compare_pads(input string name, input logic [IO_W-1:0] got,
                            input logic [IO_W-1:0] exp);
    if (got !== exp) begin
        n_mis++;
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
endtask

// One Wishbone classic transfer, held until ack or err
task automatic wb_access(input logic [WB_WIDTH-1:0] a, input logic w,
                         input logic [WB_WIDTH-1:0] d, input logic [WB_SEL_W-1:0] s,
                         input logic exp_err, output logic [WB_WIDTH-1:0] rd);
    int   cnt;
    logic got_ack;
    logic got_err;
    cnt     = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    rd      = '0;
    @(posedge clk);
    #2;
    cyc   = 1'b1;
    stb   = 1'b1;
    adr   = a;
    we    = w;
    dat_w = d;
    sel   = s;
    while (!got_ack && !got_err && cnt < ACC_LIMIT) begin
        @(negedge clk);                         // Outputs settled mid-cycle
        cnt++;
        got_ack = ack;
        got_err = err;
        rd      = dat_r;
    end
    @(posedge clk);
    #2;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    if (!got_ack && !got_err) begin
        n_fail++;
        $display("No ack or err for address 0x%h within %0d cycles", a, cnt);
    end else begin
        compare_flag("wbd_ext_err_o", got_err, exp_err);
        compare_flag("wbd_ext_ack_o", got_ack, !exp_err);
    end
endtask

// Receive one frame from the TX pad, sampled mid bit
task automatic uart_frame(output logic [7:0] b, output logic ok);
    int bt;
    ok = 1'b1;
    b  = '0;
    do @(negedge clk); while (io_out[UART_TX_PAD] !== 1'b0);
    bt = int'(sh_div) + 1;
    repeat (bt / 2) @(negedge clk);             // Middle of start bit
    if (io_out[UART_TX_PAD] !== 1'b0) begin
        ok = 1'b0;
        n_fail++;
        $display("Start bit on pad %0d did not hold low", UART_TX_PAD);
    end
    for (int i = 0; i < 8; i++) begin
        repeat (bt) @(negedge clk);
        b[i] = io_out[UART_TX_PAD];             // LSB first
    end
    repeat (bt) @(negedge clk);
    if (io_out[UART_TX_PAD] !== 1'b1) begin
        ok = 1'b0;
        n_fail++;
        $display("Stop bit on pad %0d was not high", UART_TX_PAD);
    end
endtask

`endif

//--- verif/tb_digital_core.sv
`default_nettype none

module tb_digital_core;

    import core_pkg::*;

    localparam int CLK_PER   = 40;
    localparam int TB_DIV    = 3;               // Bit time of 4 clocks
    localparam int N_SCRATCH = 8;
    localparam int N_TRANS   = 40;
    localparam int N_BYTES   = 3;
    localparam int ACC_LIMIT = 12 * (TB_DIV + 1) + 20;    // Covers one held TXDATA write
    localparam int WDOG_CYC  = N_TRANS * 50 + N_BYTES * 11 * (TB_DIV + 1);

    logic                clk, rst, cyc, stb, we;
    logic [WB_WIDTH-1:0] adr, dat_w, dat_r;
    logic [WB_SEL_W-1:0] sel;
    logic                ack, err;
    logic [IO_W-1:0]     io_out, io_oeb;
    logic [IRQ_W-1:0]    user_irq;

    int n_mis  = 0;                             // Value mismatches
    int n_fail = 0;                             // Protocol and timing failures
    int frames_seen = 0;

    // Shadow of the register rules
    logic [WB_WIDTH-1:0] sh_scratch = '0;
    logic [IRQ_W-1:0]    sh_irq     = '0;
    logic [GPO_W-1:0]    sh_gpo     = '0;
    logic                sh_tx_en   = 1'b0;
    logic [15:0]         sh_div     = UART_DIV_RST;
    logic [7:0]          sh_txdata  = '0;

    logic [WB_WIDTH-1:0] rd_got[$], rd_exp[$];
    logic [7:0]          rx_got[$], exp_bytes[$];

    `include "tb_tasks.svh"

    digital_core dut0 (
        .wb_clk_i      (clk),    .rst_i         (rst),
        .wbd_ext_cyc_i (cyc),    .wbd_ext_stb_i (stb),
        .wbd_ext_adr_i (adr),    .wbd_ext_we_i  (we),
        .wbd_ext_dat_i (dat_w),  .wbd_ext_sel_i (sel),
        .wbd_ext_dat_o (dat_r),  .wbd_ext_ack_o (ack),
        .wbd_ext_err_o (err),    .io_out_o      (io_out),
        .io_oeb_o      (io_oeb), .user_irq_o    (user_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [WB_WIDTH-1:0] reg_adr(input logic [3:0] slv, input logic [1:0] idx);
        logic [WB_WIDTH-1:0] a;
        a = '0;
        a[SLV_FIELD_HI:SLV_FIELD_LO] = slv;
        a[REG_IDX_HI:REG_IDX_LO]     = idx;
        return a;
    endfunction

    function automatic void model_write(input logic [3:0] slv, input logic [1:0] idx,
                                        input logic [WB_WIDTH-1:0] d, input logic [WB_SEL_W-1:0] s);
        if (slv == SLV_GLBL && idx == GLBL_SCRATCH) begin
            for (int i = 0; i < WB_SEL_W; i++) begin
                if (s[i]) sh_scratch[i*8 +: 8] = d[i*8 +: 8];    // Byte merge
            end
        end
        if (slv == SLV_GLBL && idx == GLBL_IRQ && s[0]) sh_irq = d[IRQ_W-1:0];
        if (slv == SLV_GLBL && idx == GLBL_GPO) begin
            if (s[0]) sh_gpo[7:0]  = d[7:0];
            if (s[1]) sh_gpo[15:8] = d[15:8];
        end
        if (slv == SLV_UART && idx == UART_CTRL && s[0]) sh_tx_en = d[0];
        if (slv == SLV_UART && idx == UART_DIV) begin
            if (s[0]) sh_div[7:0]  = d[7:0];
            if (s[1]) sh_div[15:8] = d[15:8];
        end
        if (slv == SLV_UART && idx == UART_TXDATA && sh_tx_en && s[0]) begin
            sh_txdata = d[7:0];
            exp_bytes.push_back(d[7:0]);        // Frame expected on the pad
        end
    endfunction

    // Expected read data; STATUS is timing dependent and checked on its own
    function automatic logic [WB_WIDTH-1:0] ref_read(input logic [3:0] slv, input logic [1:0] idx);
        logic [WB_WIDTH-1:0] v;
        v = '0;
        if (slv == SLV_GLBL) begin
            case (idx)
                GLBL_ID:      v = CHIP_ID;
                GLBL_SCRATCH: v = sh_scratch;
                GLBL_IRQ:     v[IRQ_W-1:0] = sh_irq;
                default:      v[GPO_W-1:0] = sh_gpo;
            endcase
        end else if (slv == SLV_UART) begin
            case (idx)
                UART_CTRL:   v[0]    = sh_tx_en;
                UART_DIV:    v[15:0] = sh_div;
                UART_TXDATA: v[7:0]  = sh_txdata;
                default:     v       = '0;
            endcase
        end else begin
            v = ERR_RDATA;
        end
        return v;
    endfunction

    task automatic write_reg(input logic [3:0] slv, input logic [1:0] idx,
                             input logic [WB_WIDTH-1:0] d, input logic [WB_SEL_W-1:0] s);
        logic [WB_WIDTH-1:0] rd;
        wb_access(reg_adr(slv, idx), 1'b1, d, s, 1'b0, rd);
        model_write(slv, idx, d, s);
    endtask

    task automatic read_reg(input logic [3:0] slv, input logic [1:0] idx);
        logic [WB_WIDTH-1:0] rd;
        wb_access(reg_adr(slv, idx), 1'b0, '0, 4'hf, 1'b0, rd);
        rd_got.push_back(rd);
        rd_exp.push_back(ref_read(slv, idx));
    endtask

    // Pad outputs and enables while the TX line is idle
    task automatic check_pads();
        logic [IO_W-1:0] exp_out;
        logic [IO_W-1:0] exp_oeb;
        exp_out              = '0;              // Unused pads low
        exp_out[GPO_W-1:0]   = sh_gpo;
        exp_out[UART_TX_PAD] = 1'b1;            // Line idle
        exp_oeb              = '1;              // Unused pads and RX undriven
        exp_oeb[GPO_W-1:0]   = '0;
        exp_oeb[UART_TX_PAD] = 1'b0;
        compare_pads("io_out_o", io_out, exp_out);
        compare_pads("io_oeb_o", io_oeb, exp_oeb);
    endtask

    // --------------------------------------------------
    // Compare process and UART decoder
    // --------------------------------------------------
    initial begin
        logic [WB_WIDTH-1:0] g, e;
        logic [7:0]          gb, eb;
        forever begin
            @(negedge clk);
            while (rd_got.size() > 0) begin
                g = rd_got.pop_front();
                e = rd_exp.pop_front();
                compare_data("wbd_ext_dat_o", g, e);
            end
            while (rx_got.size() > 0) begin
                gb = rx_got.pop_front();
                if (exp_bytes.size() == 0) begin
                    n_fail++;
                    $display("Frame 0x%h on the TX pad with no byte expected", gb);
                end else begin
                    eb = exp_bytes.pop_front();
                    compare_byte(gb, eb);
                end
            end
        end
    end

    initial begin
        logic [7:0] b;
        logic       ok;
        wait (rst === 1'b0);
        forever begin
            uart_frame(b, ok);
            frames_seen++;
            if (ok) rx_got.push_back(b);
        end
    end

    // Watchdog sized from transaction and frame counts
    initial begin
        #(WDOG_CYC * CLK_PER);
        n_fail++;
        $display("Watchdog expired after %0d cycles, run stopped", WDOG_CYC);
        $display("mismatches %0d, other failures %0d", n_mis, n_fail);
        $display("Errors found");
        $finish;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        logic [WB_WIDTH-1:0] r, s, rd;
        int                  cnt, base;
        logic                low_seen;
        void'($urandom(32'hbcb36299));
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = '0;
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;

        // After reset
        read_reg(SLV_GLBL, GLBL_ID);
        @(negedge clk);
        compare_irq(user_irq, '0);
        compare_flag("io_out_o[37]", io_out[UART_TX_PAD], 1'b1);            // Line idle
        compare_data("io_out_o[15:0]", {{(WB_WIDTH-GPO_W){1'b0}}, io_out[GPO_W-1:0]}, '0);
        check_pads();

        // Scratch byte merge
        for (int i = 0; i < N_SCRATCH; i++) begin
            r = $urandom();
            s = $urandom();
            write_reg(SLV_GLBL, GLBL_SCRATCH, r, s[WB_SEL_W-1:0]);
            read_reg(SLV_GLBL, GLBL_SCRATCH);
        end

        // IRQ and GPO reach the pins
        repeat (2) begin
            r = $urandom();
            write_reg(SLV_GLBL, GLBL_IRQ, r, 4'hf);
            write_reg(SLV_GLBL, GLBL_GPO, $urandom(), 4'hf);
            compare_irq(user_irq, sh_irq);
            compare_data("io_out_o[15:0]", {{(WB_WIDTH-GPO_W){1'b0}}, io_out[GPO_W-1:0]},
                         {{(WB_WIDTH-GPO_W){1'b0}}, sh_gpo});
            check_pads();
            read_reg(SLV_GLBL, GLBL_IRQ);
            read_reg(SLV_GLBL, GLBL_GPO);
        end

        // Unmapped select code
        wb_access({4'h7, 28'h0000_004}, 1'b0, '0, 4'hf, 1'b1, rd);
        compare_data("wbd_ext_dat_o", rd, ERR_RDATA);
        wb_access({4'hc, 28'h0}, 1'b1, $urandom(), 4'hf, 1'b1, rd);

        // Three frames back to back
        write_reg(SLV_UART, UART_DIV, TB_DIV, 4'hf);
        read_reg(SLV_UART, UART_DIV);
        write_reg(SLV_UART, UART_CTRL, 32'h1, 4'hf);
        for (int i = 0; i < N_BYTES; i++) begin
            r = $urandom();
            write_reg(SLV_UART, UART_TXDATA, {24'b0, r[7:0]}, 4'h1);          // Later ones held
        end
        read_reg(SLV_UART, UART_TXDATA);
        wb_access(reg_adr(SLV_UART, UART_STATUS), 1'b0, '0, 4'hf, 1'b0, rd);
        compare_flag("uart status busy", rd[0], 1'b1);
        cnt = 0;
        while (exp_bytes.size() > 0 && cnt < N_BYTES * 11 * (TB_DIV + 1)) begin
            @(negedge clk);
            cnt++;
        end
        if (exp_bytes.size() > 0) begin
            n_fail++;
            $display("%0d frames never arrived on the TX pad", exp_bytes.size());
        end
        repeat (2 * (TB_DIV + 1)) @(negedge clk);                           // Past the stop bit
        wb_access(reg_adr(SLV_UART, UART_STATUS), 1'b0, '0, 4'hf, 1'b0, rd);
        compare_flag("uart status busy", rd[0], 1'b0);

        // Disabled transmitter drops data
        write_reg(SLV_UART, UART_CTRL, '0, 4'hf);
        base = frames_seen;
        write_reg(SLV_UART, UART_TXDATA, $urandom(), 4'h1);
        low_seen = 1'b0;
        repeat (20 * (TB_DIV + 1)) begin
            @(negedge clk);
            if (io_out[UART_TX_PAD] !== 1'b1) low_seen = 1'b1;
        end
        if (low_seen || frames_seen != base) begin
            n_fail++;
            $display("TX pad left idle state while the transmitter was disabled");
        end
        read_reg(SLV_UART, UART_TXDATA);
        read_reg(SLV_UART, UART_CTRL);

        repeat (2) @(negedge clk);                                          // Drain compares
        if (exp_bytes.size() > 0) begin
            n_fail++;
            $display("%0d expected bytes never seen on the TX pad", exp_bytes.size());
        end
        $display("mismatches %0d, other failures %0d", n_mis, n_fail);
        if (n_mis == 0 && n_fail == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verif
design/core_pkg.sv
design/wb_stage.sv
design/wb_interconnect.sv
design/glbl_cfg.sv
design/uart_core.sv
design/digital_core.sv
verif/tb_digital_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the digital_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_digital_core -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
